// File: rtg_display_top.f
source/rtg_pkg.sv
source/mem_arbiter.sv
source/pixel_fetch.sv
source/audio_fetch.sv
source/osd_overlay.sv
source/rtg_display_top.sv
verif/tb_clock_gen.sv
verif/tb_rtg_display_top.sv

// File: run_sim.sh
#!/bin/sh
# Builds the RTG display testbench with Verilator and runs it.
# Exit status is 0 only when the simulation prints the pass message.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  -f rtg_display_top.f --top-module tb_rtg_display_top -o tb_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/tb_sim)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if printf '%s\n' "$sim_out" | grep -qxF '** PASS **'; then
  exit 0
fi
exit 1

// File: source/audio_fetch.sv
// Auxiliary audio fetch. Every SAMPLE_DIV clocks one word is read from the
// audio buffer; the byte-swapped word lands in left and right by turns
// and aud_strobe pulses once per update.

`timescale 1ns/1ps
`default_nettype none

module audio_fetch #(
  parameter logic [rtg_pkg::ADDR_W-1:0] AUDIO_BASE  = 24'h6F_0000,
  parameter int                         AUDIO_WORDS = 32,
  parameter int                         SAMPLE_DIV  = 643
) (
  input  logic                       clk_vid,
  input  logic                       rst_n,
  input  logic                       aud_ena,
  output logic                       aud_req_valid,
  output logic [rtg_pkg::ADDR_W-1:0] aud_req_addr,
  input  logic                       aud_req_ready,
  input  logic                       aud_rsp_valid,
  input  logic [rtg_pkg::DATA_W-1:0] rsp_data,
  output logic [rtg_pkg::DATA_W-1:0] aud_left,
  output logic [rtg_pkg::DATA_W-1:0] aud_right,
  output logic                       aud_strobe
);

  localparam int DIV_W = (SAMPLE_DIV > 1) ? $clog2(SAMPLE_DIV) : 1;
  localparam int IDX_W = (AUDIO_WORDS > 1) ? $clog2(AUDIO_WORDS) : 1;
  localparam logic [DIV_W-1:0] LAST_DIV = DIV_W'(SAMPLE_DIV - 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(AUDIO_WORDS - 1);

  logic [DIV_W-1:0] div_cnt;
  logic             tick;
  logic             tick_pend;   // Tick seen, request not yet accepted
  logic             busy;        // Request accepted, data not back
  logic [IDX_W-1:0] idx;
  logic             lr_sel;      // 0 left, 1 right

  assign tick          = aud_ena && (div_cnt == LAST_DIV);
  assign aud_req_valid = tick_pend && !busy;
  assign aud_req_addr  = AUDIO_BASE + {{(rtg_pkg::ADDR_W - IDX_W){1'b0}}, idx};

  // Sample rate divider
  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n)                 div_cnt <= '0;
    else if (!aud_ena || tick)  div_cnt <= '0;
    else                        div_cnt <= div_cnt + 1'b1;
  end

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      tick_pend  <= 1'b0;
      busy       <= 1'b0;
      idx        <= '0;
      lr_sel     <= 1'b0;
      aud_left   <= '0;
      aud_right  <= '0;
      aud_strobe <= 1'b0;
    end else begin
      aud_strobe <= 1'b0;
      if (aud_req_valid && aud_req_ready) begin
        tick_pend <= 1'b0;
        busy      <= 1'b1;
        idx       <= (idx == LAST_IDX) ? '0 : idx + 1'b1;
      end
      if (tick) tick_pend <= 1'b1;       // Merges with one already waiting
      if (aud_rsp_valid) begin
        busy       <= 1'b0;
        lr_sel     <= ~lr_sel;
        aud_strobe <= 1'b1;
        if (lr_sel) aud_right <= {rsp_data[7:0], rsp_data[15:8]};
        else        aud_left  <= {rsp_data[7:0], rsp_data[15:8]};
      end
      // Rewind while disabled once nothing is pending or in flight
      if (!aud_ena && !tick_pend && !busy) begin
        idx    <= '0;
        lr_sel <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/mem_arbiter.sv
// Shares the single external memory read port between the pixel and
// audio fetch engines. One request in flight at a time; the owner keeps
// the port until its response comes back.

`timescale 1ns/1ps
`default_nettype none

module mem_arbiter (
  input  logic                       clk_vid,
  input  logic                       rst_n,
  // Video client
  input  logic                       vid_req_valid,
  input  logic [rtg_pkg::ADDR_W-1:0] vid_req_addr,
  output logic                       vid_req_ready,
  output logic                       vid_rsp_valid,
  input  logic                       vid_pri,
  // Audio client
  input  logic                       aud_req_valid,
  input  logic [rtg_pkg::ADDR_W-1:0] aud_req_addr,
  output logic                       aud_req_ready,
  output logic                       aud_rsp_valid,
  // External memory
  output logic                       mem_valid,
  output logic [rtg_pkg::ADDR_W-1:0] mem_addr,
  input  logic                       mem_ready,
  input  logic                       mem_rvalid,
  input  logic [rtg_pkg::DATA_W-1:0] mem_rdata,
  output logic [rtg_pkg::DATA_W-1:0] rsp_data
);

  rtg_pkg::arb_state_e state;
  logic                req_done;   // Owner's request already accepted
  logic                any_req;
  logic                pick_vid;
  logic                sel_vid;
  logic                req_phase;

  assign any_req  = vid_req_valid || aud_req_valid;
  assign pick_vid = vid_req_valid && (vid_pri || !aud_req_valid);

  // Choice is fresh in idle, locked once a client owns the port
  assign sel_vid   = (state == rtg_pkg::ARB_IDLE) ? pick_vid : (state == rtg_pkg::ARB_VIDEO);
  assign req_phase = (state == rtg_pkg::ARB_IDLE) || !req_done;

  assign mem_addr  = sel_vid ? vid_req_addr : aud_req_addr;
  assign mem_valid = (state == rtg_pkg::ARB_IDLE) ? any_req :
                     (!req_done && (sel_vid ? vid_req_valid : aud_req_valid));

  assign vid_req_ready = mem_ready && req_phase && sel_vid;
  assign aud_req_ready = mem_ready && req_phase && !sel_vid;

  // Response goes back to whoever owns the port
  assign vid_rsp_valid = mem_rvalid && (state == rtg_pkg::ARB_VIDEO);
  assign aud_rsp_valid = mem_rvalid && (state == rtg_pkg::ARB_AUDIO);
  assign rsp_data      = mem_rdata;

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      state    <= rtg_pkg::ARB_IDLE;
      req_done <= 1'b0;
    end else begin
      case (state)
        rtg_pkg::ARB_IDLE: begin
          if (any_req) begin
            state    <= pick_vid ? rtg_pkg::ARB_VIDEO : rtg_pkg::ARB_AUDIO;
            req_done <= mem_ready;                 // Accepted on first cycle
          end
        end
        default: begin
          if (mem_valid && mem_ready) req_done <= 1'b1;
          if (mem_rvalid) begin                    // Release the port
            state    <= rtg_pkg::ARB_IDLE;
            req_done <= 1'b0;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: source/osd_overlay.sv
// Output stage. Expands RGB565 pixels to 8 bits per channel, blends the
// OSD pattern inside a column window and flags the last pixel of a line.
// Single register stage; a new pixel is taken whenever the slot frees up.

`timescale 1ns/1ps
`default_nettype none

module osd_overlay #(
  parameter  int LINE_PIXELS = 16,
  localparam int COL_W       = $clog2(LINE_PIXELS + 1)
) (
  input  logic                       clk_vid,
  input  logic                       rst_n,
  input  logic                       pix_valid,
  output logic                       pix_ready,
  input  logic [rtg_pkg::DATA_W-1:0] pix_data,
  input  logic                       osd_enable,
  input  logic [COL_W-1:0]           osd_left,
  input  logic [COL_W-1:0]           osd_right,
  input  logic [15:0]                osd_pattern,
  input  logic                       hsync_pol,
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [rtg_pkg::CHAN_W-1:0] out_r,
  output logic [rtg_pkg::CHAN_W-1:0] out_g,
  output logic [rtg_pkg::CHAN_W-1:0] out_b,
  output logic                       out_line_end
);

  localparam logic [COL_W-1:0] LAST_COL = COL_W'(LINE_PIXELS - 1);

  logic [COL_W-1:0]           col;
  logic [COL_W+3:0]           col_ext;
  logic                       take;
  logic                       in_win;
  logic                       pat_bit;
  logic [1:0]                 osd_r, osd_g, osd_b;
  logic [rtg_pkg::CHAN_W-1:0] exp_r, exp_g, exp_b;

  assign pix_ready = out_ready || !out_valid;
  assign take      = pix_valid && pix_ready;

  // Replicate top bits into the low end
  assign exp_r = {pix_data[15:11], pix_data[15:13]};
  assign exp_g = {pix_data[10:5],  pix_data[10:9]};
  assign exp_b = {pix_data[4:0],   pix_data[4:2]};

  assign in_win  = osd_enable && (col >= osd_left) && (col < osd_right);
  assign col_ext = {4'b0000, col};
  assign pat_bit = osd_pattern[col_ext[3:0]];   // Pattern repeats every 16 columns
  assign osd_r   = pat_bit ? rtg_pkg::OSD_FG_R : rtg_pkg::OSD_BG_R;
  assign osd_g   = pat_bit ? rtg_pkg::OSD_FG_G : rtg_pkg::OSD_BG_G;
  assign osd_b   = pat_bit ? rtg_pkg::OSD_FG_B : rtg_pkg::OSD_BG_B;

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      col       <= '0;
    end else if (take) begin
      out_valid <= 1'b1;
      col       <= (col == LAST_COL) ? '0 : col + 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // Pixel payload
  always_ff @(posedge clk_vid) begin
    if (take) begin
      out_r        <= in_win ? {osd_r, exp_r[rtg_pkg::CHAN_W-1:2]} : exp_r;
      out_g        <= in_win ? {osd_g, exp_g[rtg_pkg::CHAN_W-1:2]} : exp_g;
      out_b        <= in_win ? {osd_b, exp_b[rtg_pkg::CHAN_W-1:2]} : exp_b;
      out_line_end <= (col == LAST_COL) ^ hsync_pol;
    end
  end

endmodule

`default_nettype wire

// File: source/pixel_fetch.sv
// Reads the frame buffer word by word from frame_base, wrapping after
// FRAME_WORDS, and queues the words in a small FIFO for the output stage.
// Requests stop once stored plus in-flight words would fill the FIFO.

`timescale 1ns/1ps
`default_nettype none

module pixel_fetch #(
  parameter int FRAME_WORDS = 64,
  parameter int FIFO_DEPTH  = 8
) (
  input  logic                       clk_vid,
  input  logic                       rst_n,
  input  logic [rtg_pkg::ADDR_W-1:0] frame_base,
  output logic                       vid_req_valid,
  output logic [rtg_pkg::ADDR_W-1:0] vid_req_addr,
  input  logic                       vid_req_ready,
  input  logic                       vid_rsp_valid,
  input  logic [rtg_pkg::DATA_W-1:0] rsp_data,
  output logic                       vid_pri,
  output logic                       pix_valid,
  input  logic                       pix_ready,
  output logic [rtg_pkg::DATA_W-1:0] pix_data
);

  localparam int IDX_W = (FRAME_WORDS > 1) ? $clog2(FRAME_WORDS) : 1;
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(FRAME_WORDS - 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W:0]   DEPTH_V  = (CNT_W + 1)'(FIFO_DEPTH);
  localparam logic [CNT_W:0]   HALF_V   = (CNT_W + 1)'(FIFO_DEPTH / 2);

  logic [rtg_pkg::DATA_W-1:0] fifo_mem [FIFO_DEPTH];
  logic [PTR_W-1:0]           wr_ptr;
  logic [PTR_W-1:0]           rd_ptr;
  logic [CNT_W-1:0]           fill;      // Words stored
  logic [CNT_W-1:0]           out_cnt;   // Words requested, not yet returned
  logic [CNT_W:0]             used;
  logic [IDX_W-1:0]           idx;
  logic                       req_fire;
  logic                       pop;

  assign used          = {1'b0, fill} + {1'b0, out_cnt};
  assign vid_req_valid = used < DEPTH_V;   // Falls only after a request fires
  assign vid_req_addr  = frame_base + {{(rtg_pkg::ADDR_W - IDX_W){1'b0}}, idx};
  assign vid_pri       = {1'b0, fill} < HALF_V;
  assign req_fire      = vid_req_valid && vid_req_ready;

  assign pix_valid = fill != '0;
  assign pix_data  = fifo_mem[rd_ptr];
  assign pop       = pix_valid && pix_ready;

  ////////////////////////////////////////////////////////////////////////////
  // Request index, counters and pointers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_vid or negedge rst_n) begin
    if (!rst_n) begin
      idx     <= '0;
      out_cnt <= '0;
      fill    <= '0;
      wr_ptr  <= '0;
      rd_ptr  <= '0;
    end else begin
      if (req_fire) idx <= (idx == LAST_IDX) ? '0 : idx + 1'b1;
      out_cnt <= out_cnt + CNT_W'(req_fire) - CNT_W'(vid_rsp_valid);
      fill    <= fill + CNT_W'(vid_rsp_valid) - CNT_W'(pop);
      if (vid_rsp_valid) wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
      if (pop) rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
    end
  end

  // Storage is written on the response cycle
  always_ff @(posedge clk_vid) begin
    if (vid_rsp_valid) fifo_mem[wr_ptr] <= rsp_data;
  end

endmodule

`default_nettype wire

// File: source/rtg_display_top.sv
// RTG display and auxiliary audio fetch. Pixel and audio engines share
// one external word memory through the arbiter; pixels leave through
// the OSD overlay stage. All logic runs on clk_vid.

`timescale 1ns/1ps
`default_nettype none

module rtg_display_top #(
  parameter  int                         FRAME_WORDS = 64,
  parameter  int                         LINE_PIXELS = 16,
  parameter  int                         FIFO_DEPTH  = 8,
  parameter  logic [rtg_pkg::ADDR_W-1:0] AUDIO_BASE  = 24'h6F_0000,
  parameter  int                         AUDIO_WORDS = 32,
  parameter  int                         SAMPLE_DIV  = 643,
  localparam int                         COL_W       = $clog2(LINE_PIXELS + 1)
) (
  input  logic                       clk_vid,
  input  logic                       rst_n,
  // Control
  input  logic [rtg_pkg::ADDR_W-1:0] frame_base,
  input  logic                       aud_ena,
  input  logic                       osd_enable,
  input  logic [COL_W-1:0]           osd_left,
  input  logic [COL_W-1:0]           osd_right,
  input  logic [15:0]                osd_pattern,
  input  logic                       hsync_pol,
  // Shared memory
  output logic                       mem_valid,
  output logic [rtg_pkg::ADDR_W-1:0] mem_addr,
  input  logic                       mem_ready,
  input  logic                       mem_rvalid,
  input  logic [rtg_pkg::DATA_W-1:0] mem_rdata,
  // Video out
  output logic                       out_valid,
  input  logic                       out_ready,
  output logic [rtg_pkg::CHAN_W-1:0] out_r,
  output logic [rtg_pkg::CHAN_W-1:0] out_g,
  output logic [rtg_pkg::CHAN_W-1:0] out_b,
  output logic                       out_line_end,
  // Audio out
  output logic [rtg_pkg::DATA_W-1:0] aud_left,
  output logic [rtg_pkg::DATA_W-1:0] aud_right,
  output logic                       aud_strobe
);

  logic                       vid_req_valid, vid_req_ready, vid_rsp_valid, vid_pri;
  logic [rtg_pkg::ADDR_W-1:0] vid_req_addr;
  logic                       aud_req_valid, aud_req_ready, aud_rsp_valid;
  logic [rtg_pkg::ADDR_W-1:0] aud_req_addr;
  logic [rtg_pkg::DATA_W-1:0] rsp_data;
  logic                       pix_valid, pix_ready;
  logic [rtg_pkg::DATA_W-1:0] pix_data;

  mem_arbiter u_mem_arbiter (
    .clk_vid, .rst_n,
    .vid_req_valid, .vid_req_addr, .vid_req_ready, .vid_rsp_valid, .vid_pri,
    .aud_req_valid, .aud_req_addr, .aud_req_ready, .aud_rsp_valid,
    .mem_valid, .mem_addr, .mem_ready, .mem_rvalid, .mem_rdata, .rsp_data
  );

  pixel_fetch #(.FRAME_WORDS(FRAME_WORDS), .FIFO_DEPTH(FIFO_DEPTH)) u_pixel_fetch (
    .clk_vid, .rst_n, .frame_base,
    .vid_req_valid, .vid_req_addr, .vid_req_ready, .vid_rsp_valid, .rsp_data,
    .vid_pri, .pix_valid, .pix_ready, .pix_data
  );

  audio_fetch #(
    .AUDIO_BASE(AUDIO_BASE), .AUDIO_WORDS(AUDIO_WORDS), .SAMPLE_DIV(SAMPLE_DIV)
  ) u_audio_fetch (
    .clk_vid, .rst_n, .aud_ena,
    .aud_req_valid, .aud_req_addr, .aud_req_ready, .aud_rsp_valid, .rsp_data,
    .aud_left, .aud_right, .aud_strobe
  );

  osd_overlay #(.LINE_PIXELS(LINE_PIXELS)) u_osd_overlay (
    .clk_vid, .rst_n, .pix_valid, .pix_ready, .pix_data,
    .osd_enable, .osd_left, .osd_right, .osd_pattern, .hsync_pol,
    .out_valid, .out_ready, .out_r, .out_g, .out_b, .out_line_end
  );

endmodule

`default_nettype wire

// File: source/rtg_pkg.sv
// Shared widths, OSD colours and arbiter state encoding for the RTG
// display and audio fetch block. Modules refer to these by scoped name.

`default_nettype none

package rtg_pkg;

  // Bus widths
  localparam int ADDR_W = 24;   // Word address into shared memory
  localparam int DATA_W = 16;   // Memory word, also one RGB565 pixel
  localparam int CHAN_W = 8;    // One expanded output colour channel

  ////////////////////////////////////////////////////////////////////////////
  // OSD colours, 2 bits per channel
  ////////////////////////////////////////////////////////////////////////////

  // Pattern bit set
  localparam logic [1:0] OSD_FG_R = 2'b11;
  localparam logic [1:0] OSD_FG_G = 2'b11;
  localparam logic [1:0] OSD_FG_B = 2'b11;

  // Pattern bit clear gives a blue tint
  localparam logic [1:0] OSD_BG_R = 2'b00;
  localparam logic [1:0] OSD_BG_G = 2'b00;
  localparam logic [1:0] OSD_BG_B = 2'b10;

  // Memory port ownership
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_VIDEO,
    ARB_AUDIO
  } arb_state_e;

endpackage

`default_nettype wire

// File: verif/tb_clock_gen.sv
// Clock and reset source for the testbench. Free-running clock of the
// given period; reset held low for a number of cycles, then released.

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS    = 4,
  parameter int RESET_CYCLES = 5
) (
  output logic clk_vid,
  output logic rst_n
);

  initial begin
    clk_vid = 1'b0;
    forever #(PERIOD_NS / 2) clk_vid = ~clk_vid;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_vid);
    rst_n <= 1'b1;   // Released on a rising edge
  end

endmodule

`default_nettype wire

// File: verif/tb_rtg_display_top.sv
// Testbench for the RTG display and audio fetch block. Models the shared
// word memory with random ready and latency, applies random back-pressure
// on the pixel output and checks pixels, OSD overlay, line end, audio
// samples and the memory protocol with immediate assertions.

`timescale 1ns/1ps
`default_nettype none

module tb_rtg_display_top;

  localparam int          FRAME_WORDS = 64;
  localparam int          LINE_PIXELS = 16;
  localparam int          AUDIO_WORDS = 32;
  localparam int          SAMPLE_DIV  = 24;
  localparam int          COL_W       = $clog2(LINE_PIXELS + 1);
  localparam logic [23:0] AUDIO_BASE  = 24'h6F_0000;
  localparam logic [23:0] FRAME_BASE  = 24'h01_2340;
  localparam int          N_ORDER     = 128;   // Two full frames
  localparam int          N_OSD       = 48;
  localparam int          N_POL       = 48;
  localparam int          AUD_STROBES = 68;
  localparam int          TIMEOUT     = 16 * (N_ORDER + N_OSD + N_POL)
                                        + 3 * SAMPLE_DIV * AUD_STROBES + 500;

  logic                       clk_vid, rst_n;
  logic [rtg_pkg::ADDR_W-1:0] frame_base  = FRAME_BASE;
  logic                       aud_ena     = 1'b1;
  logic                       osd_enable  = 1'b0;
  logic [COL_W-1:0]           osd_left    = COL_W'(3);
  logic [COL_W-1:0]           osd_right   = COL_W'(11);
  logic [15:0]                osd_pattern = 16'hA5C3;
  logic                       hsync_pol   = 1'b0;
  logic                       mem_valid, mem_rvalid = 1'b0, mem_ready = 1'b0;
  logic [rtg_pkg::ADDR_W-1:0] mem_addr;
  logic [rtg_pkg::DATA_W-1:0] mem_rdata   = '0;
  logic                       out_valid, out_ready = 1'b0, out_line_end;
  logic [rtg_pkg::CHAN_W-1:0] out_r, out_g, out_b;
  logic [rtg_pkg::DATA_W-1:0] aud_left, aud_right;
  logic                       aud_strobe;

  int          errors = 0, err_mark = 0, tests_run = 0, tests_failed = 0;
  int          cyc = 0, out_count = 0, aud_count = 0, cfg_from = 0;
  int          outstanding = 0, stalls = 0;
  int unsigned ready_pct = 30;
  logic        hold_out = 1'b0, seen_req = 1'b0, m_en, m_pol;
  logic        prev_stall = 1'b0;
  logic [23:0] prev_addr;
  logic [23:0] addr_q[$];
  int          due_q[$];

  tb_clock_gen #(.PERIOD_NS(4), .RESET_CYCLES(5)) u_tb_clock_gen (.clk_vid, .rst_n);

  rtg_display_top #(
    .FRAME_WORDS(FRAME_WORDS), .LINE_PIXELS(LINE_PIXELS), .FIFO_DEPTH(8),
    .AUDIO_BASE(AUDIO_BASE), .AUDIO_WORDS(AUDIO_WORDS), .SAMPLE_DIV(SAMPLE_DIV)
  ) u_rtg_display_top (
    .clk_vid, .rst_n, .frame_base, .aud_ena, .osd_enable, .osd_left, .osd_right,
    .osd_pattern, .hsync_pol, .mem_valid, .mem_addr, .mem_ready, .mem_rvalid,
    .mem_rdata, .out_valid, .out_ready, .out_r, .out_g, .out_b, .out_line_end,
    .aud_left, .aud_right, .aud_strobe
  );

  function automatic logic [15:0] mem_word(input logic [23:0] addr);
    return addr[15:0] ^ 16'h5A5A;   // Memory contents
  endfunction

  function automatic logic [7:0] widen5(input logic [4:0] v);
    return {v, v[4:2]};
  endfunction

  function automatic logic [7:0] widen6(input logic [5:0] v);
    return {v, v[5:4]};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Memory model and output back-pressure
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_vid) begin
    cyc        <= cyc + 1;
    mem_rvalid <= 1'b0;
    if (rst_n) begin
      mem_ready <= ($urandom % 4) != 0;
      if (mem_valid && mem_ready) begin
        addr_q.push_back(mem_addr);
        due_q.push_back(cyc + int'($urandom % 4));   // 1 to 4 cycles later
        seen_req <= 1'b1;
      end
      if (addr_q.size() != 0 && due_q[0] <= cyc) begin
        mem_rvalid <= 1'b1;
        mem_rdata  <= mem_word(addr_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  always @(posedge clk_vid) begin
    if (hold_out) out_ready <= 1'b0;
    else          out_ready <= ($urandom % 100) < ready_pct;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checkers
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_vid) begin
    if (!seen_req) begin
      assert (!out_valid && !aud_strobe) else begin
        errors++;
        $display("Output or audio strobe active before the first memory request");
      end
      assert (aud_left == '0 && aud_right == '0) else begin
        errors++;
        $display("** Error: aud_left/aud_right = %h/%h before first request", aud_left,
                 aud_right);
      end
    end
  end

  always @(posedge clk_vid) begin : pix_check
    logic [15:0] w;
    logic [7:0]  er, eg, eb;
    int          col;
    logic        win, fg, ele;
    if (rst_n && out_valid && out_ready) begin
      if (out_count >= cfg_from) begin   // Config seen by this pixel at entry
        m_en  = osd_enable;
        m_pol = hsync_pol;
      end
      w   = mem_word(FRAME_BASE + 24'(out_count % FRAME_WORDS));
      er  = widen5(w[15:11]);
      eg  = widen6(w[10:5]);
      eb  = widen5(w[4:0]);
      col = out_count % LINE_PIXELS;
      win = m_en && col >= int'(osd_left) && col < int'(osd_right);
      fg  = osd_pattern[4'(col)];
      if (win) begin
        er = {fg ? 2'b11 : 2'b00, er[7:2]};
        eg = {fg ? 2'b11 : 2'b00, eg[7:2]};
        eb = {fg ? 2'b11 : 2'b10, eb[7:2]};   // Background is a blue tint
      end
      ele = (col == LINE_PIXELS - 1) ^ m_pol;
      assert (out_r == er && out_g == eg && out_b == eb) else begin
        errors++;
        $display("** Error: pixel %0d out_r/g/b = %h/%h/%h, expected %h/%h/%h",
                 out_count, out_r, out_g, out_b, er, eg, eb);
      end
      assert (out_line_end == ele) else begin
        errors++;
        $display("** Error: pixel %0d out_line_end = %h, expected %h", out_count,
                 out_line_end, ele);
      end
      out_count <= out_count + 1;
    end
  end

  always @(posedge clk_vid) begin : aud_check
    logic [15:0] w;
    logic [15:0] swapped;
    if (rst_n && aud_strobe) begin
      w       = mem_word(AUDIO_BASE + 24'(aud_count % AUDIO_WORDS));
      swapped = {w[7:0], w[15:8]};
      if (aud_count % 2 == 0) begin
        assert (aud_left == swapped) else begin
          errors++;
          $display("** Error: sample %0d aud_left = %h, expected %h", aud_count,
                   aud_left, swapped);
        end
      end else begin
        assert (aud_right == swapped) else begin
          errors++;
          $display("** Error: sample %0d aud_right = %h, expected %h", aud_count,
                   aud_right, swapped);
        end
      end
      aud_count <= aud_count + 1;
    end
  end

  // Memory protocol
  always @(posedge clk_vid) begin
    if (rst_n) begin
      if (mem_valid) begin
        assert (outstanding == 0) else begin
          errors++;
          $display("New request raised while a response was still outstanding");
        end
        assert ((mem_addr >= FRAME_BASE && mem_addr < FRAME_BASE + FRAME_WORDS) ||
                (mem_addr >= AUDIO_BASE && mem_addr < AUDIO_BASE + AUDIO_WORDS)) else begin
          errors++;
          $display("** Error: mem_addr = %h outside frame and audio ranges", mem_addr);
        end
      end
      if (prev_stall) begin
        assert (mem_valid && mem_addr == prev_addr) else begin
          errors++;
          $display("** Error: mem_valid/mem_addr = %h/%h during stall of %h",
                   mem_valid, mem_addr, prev_addr);
        end
      end
      if (mem_valid && !mem_ready) stalls <= stalls + 1;
      outstanding <= outstanding + int'(mem_valid && mem_ready) - int'(mem_rvalid);
    end
    prev_stall <= rst_n && mem_valid && !mem_ready;
    prev_addr  <= mem_addr;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////////////////////

  task automatic finish_test(input string name);
    @(negedge clk_vid);   // Counters settled between edges
    tests_run++;
    if (errors == err_mark) begin
      $display("Test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: failed with %0d errors", tests_run, name, errors - err_mark);
    end
    err_mark = errors;
  endtask

  // Stall the output so the held pixel keeps the old settings
  task automatic change_config(input logic en, input logic pol);
    hold_out <= 1'b1;
    do begin
      @(posedge clk_vid);
    end while (!(out_valid && !out_ready));
    osd_enable <= en;
    hsync_pol  <= pol;
    cfg_from   <= out_count + 1;
    hold_out   <= 1'b0;
  endtask

  initial begin
    while (cyc < TIMEOUT) @(posedge clk_vid);
    $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    void'($urandom(32'hF557_8CB1));
    @(posedge rst_n);
    while (!seen_req) @(posedge clk_vid);
    finish_test("reset outputs");

    while (out_count < N_ORDER) @(posedge clk_vid);
    finish_test("pixel order and colour");

    change_config(1'b1, 1'b0);
    ready_pct <= 60;
    while (out_count < N_ORDER + N_OSD) @(posedge clk_vid);
    finish_test("OSD window");

    change_config(1'b1, 1'b1);
    ready_pct <= 90;
    while (out_count < N_ORDER + N_OSD + N_POL) @(posedge clk_vid);
    finish_test("line end polarity");

    ready_pct <= 10;   // FIFO fills, audio gets the port
    while (aud_count < AUD_STROBES) @(posedge clk_vid);
    finish_test("audio samples");

    assert (stalls > 0) else begin
      errors++;
      $display("No stalled memory request was seen");
    end
    finish_test("memory protocol");

    $display("Summary: %0d tests, %0d failed, %0d errors, %0d pixels, %0d samples",
             tests_run, tests_failed, errors, out_count, aud_count);
    if (errors == 0 && tests_failed == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire
